//--- common/profiler_settings.svh
`ifndef PROFILER_SETTINGS_SVH
`define PROFILER_SETTINGS_SVH

`define PROF_DATA_W       32
`define PROF_CTR_W        32
`define PROF_REG_ADDR_W   5
`define PROF_NUM_REGS     32
`define PROF_DMEM_ADDR_W  10  // word address bits of local dmem

// instruction field positions
`define PROF_RD_LSB         7
`define PROF_RS1_LSB        15
`define PROF_RS2_LSB        20
`define PROF_FUNCT7_LSB     25
`define PROF_OPCODE_OP      7'b0110011
`define PROF_FUNCT7_MULDIV  7'b0000001

`define PROF_NUM_STATS   17
`define PROF_STAT_SEL_W  5

`define STAT_CYCLE                0
`define STAT_INSTR                1
`define STAT_BRANCH               2
`define STAT_BRANCH_MISS          3
`define STAT_JALR                 4
`define STAT_JALR_MISS            5
`define STAT_MULDIV               6
`define STAT_LOCAL_LD             7
`define STAT_LOCAL_ST             8
`define STAT_REMOTE_LD            9
`define STAT_REMOTE_ST            10
`define STAT_ICACHE_MISS          11
`define STAT_STALL_DEPEND         12
`define STAT_STALL_DEPEND_LOCAL   13
`define STAT_STALL_DEPEND_REMOTE  14
`define STAT_STALL_MD             15
`define STAT_STALL_REMOTE_REQ     16

`endif

//--- common/profiler_pkg.sv
`default_nettype none

`include "profiler_settings.svh"

package profiler_pkg;

  // read side of a remote request payload
  typedef struct packed {
    logic                      icache_fetch;  // instruction refill, not a data load
    logic                      float_wb;
    logic [`PROF_DATA_W-3:0]   reserved;
  } remote_load_info_t;

  // write_not_read picks the view
  typedef union packed {
    logic [`PROF_DATA_W-1:0]   store_data;
    remote_load_info_t         load_info;
  } remote_payload_u;

  // dmem window is selected by one bit above the word address, upper bits zero
  function automatic logic local_dmem_hit(input logic [`PROF_DATA_W-1:0] addr);
    return addr[2+`PROF_DMEM_ADDR_W]
      & (addr[`PROF_DATA_W-1:3+`PROF_DMEM_ADDR_W] == '0);
  endfunction

endpackage

`default_nettype wire

//--- common/profiler_event_if.sv
`default_nettype none

interface profiler_event_if;

  logic instr, branch, branch_miss, jalr, jalr_miss, muldiv;
  logic local_ld, local_st, remote_ld, remote_st, icache_miss;
  logic stall_depend, stall_depend_local, stall_depend_remote;

  modport decode (
    output instr, branch, branch_miss, jalr, jalr_miss, muldiv,
    output local_ld, local_st, remote_ld, remote_st, icache_miss
  );

  modport depend (output stall_depend, stall_depend_local, stall_depend_remote);

  modport count (
    input instr, branch, branch_miss, jalr, jalr_miss, muldiv,
    input local_ld, local_st, remote_ld, remote_st, icache_miss,
    input stall_depend, stall_depend_local, stall_depend_remote
  );

endinterface

`default_nettype wire

//--- verilog/retire_event_decode.sv
`default_nettype none

`include "profiler_settings.svh"

module retire_event_decode
  import profiler_pkg::*;
(
  input  wire logic                      reset_i,
  input  wire logic                      stall_i,

  input  wire logic [`PROF_DATA_W-1:0]   exe_instr_i,
  input  wire logic                      exe_icache_miss_i,
  input  wire logic                      exe_is_branch_i,
  input  wire logic                      exe_is_jalr_i,
  input  wire logic                      exe_writes_rf_i,
  input  wire logic                      exe_reads_rf2_i,
  input  wire logic                      branch_mispredict_i,
  input  wire logic                      jalr_mispredict_i,

  input  wire logic                      lsu_dmem_v_i,
  input  wire logic                      lsu_dmem_w_i,

  input  wire logic                      remote_req_v_i,
  input  wire logic                      remote_req_yumi_i,
  input  wire logic                      remote_req_write_i,
  input  wire remote_payload_u           remote_req_payload_i,

  profiler_event_if.decode               ev
);

  logic active;
  logic instr_inc;
  logic is_muldiv;
  logic dmem_go;
  logic remote_go;
  logic remote_rd;
  logic local_ld_inc, local_st_inc;
  logic remote_ld_inc, icache_miss_inc;

  assign active = ~reset_i & ~stall_i;

  // bubbles and refetch slots carry a zero word or the miss flag
  assign instr_inc = active & (exe_instr_i != '0) & ~exe_icache_miss_i;

  assign is_muldiv = (exe_instr_i[6:0] == `PROF_OPCODE_OP)
    & (exe_instr_i[`PROF_FUNCT7_LSB +: 7] == `PROF_FUNCT7_MULDIV);

  assign ev.instr       = instr_inc;
  assign ev.branch      = instr_inc & exe_is_branch_i;
  assign ev.branch_miss = instr_inc & exe_is_branch_i & branch_mispredict_i;
  assign ev.jalr        = instr_inc & exe_is_jalr_i;
  assign ev.jalr_miss   = instr_inc & exe_is_jalr_i & jalr_mispredict_i;
  assign ev.muldiv      = instr_inc & is_muldiv;

  assign dmem_go      = active & lsu_dmem_v_i;
  assign local_ld_inc = dmem_go & ~lsu_dmem_w_i & exe_writes_rf_i;
  assign local_st_inc = dmem_go & lsu_dmem_w_i & exe_reads_rf2_i;

  // only a taken request counts, yumi low is back-pressure
  assign remote_go = ~reset_i & remote_req_v_i & remote_req_yumi_i;
  assign remote_rd = remote_go & ~remote_req_write_i;

  assign remote_ld_inc = remote_rd & ~remote_req_payload_i.load_info.icache_fetch
    & exe_writes_rf_i;
  assign icache_miss_inc = remote_rd & remote_req_payload_i.load_info.icache_fetch;

  assign ev.local_ld    = local_ld_inc;
  assign ev.local_st    = local_st_inc;
  assign ev.remote_ld   = remote_ld_inc;
  assign ev.remote_st   = remote_go & remote_req_write_i;
  assign ev.icache_miss = icache_miss_inc;

  always_comb begin
    assert (!(local_ld_inc && local_st_inc))
      else $error("local load and store strobes high together");
    assert (!(remote_ld_inc && icache_miss_inc))
      else $error("remote load and icache miss strobes high together");
  end

endmodule

`default_nettype wire

//--- verilog/load_origin_scoreboard.sv
`default_nettype none

`include "profiler_settings.svh"

module load_origin_scoreboard
  import profiler_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire logic                          stall_i,
  input  wire logic                          stall_depend_i,

  input  wire logic [`PROF_DATA_W-1:0]       id_instr_i,
  input  wire logic                          id_reads_rf1_i,
  input  wire logic                          id_reads_rf2_i,

  input  wire logic                          int_sb_score_i,
  input  wire logic [`PROF_DATA_W-1:0]       load_base_i,
  input  wire logic [`PROF_DATA_W-1:0]       load_offset_i,
  input  wire logic                          sb_clear_local_i,
  input  wire logic [`PROF_REG_ADDR_W-1:0]   sb_clear_local_id_i,
  input  wire logic                          sb_clear_remote_i,
  input  wire logic [`PROF_REG_ADDR_W-1:0]   sb_clear_remote_id_i,

  profiler_event_if.depend                   ev
);

  // bit 0 local load pending, bit 1 remote load pending
  logic [`PROF_NUM_REGS-1:0][1:0] sb_r;

  logic [`PROF_DATA_W-1:0]                load_addr;
  logic                                   addr_local;
  logic [1:0]                             score;
  logic [1:0]                             clear;
  logic [1:0][`PROF_REG_ADDR_W-1:0]       clear_id;
  logic [`PROF_REG_ADDR_W-1:0]            rd, rs1, rs2;
  logic [1:0]                             dep_hit;
  logic                                   depend_inc;
  logic                                   depend_local_inc;
  logic                                   depend_remote_inc;

  assign rd  = id_instr_i[`PROF_RD_LSB  +: `PROF_REG_ADDR_W];
  assign rs1 = id_instr_i[`PROF_RS1_LSB +: `PROF_REG_ADDR_W];
  assign rs2 = id_instr_i[`PROF_RS2_LSB +: `PROF_REG_ADDR_W];

  assign load_addr  = load_base_i + load_offset_i;
  assign addr_local = local_dmem_hit(load_addr);

  assign score    = {int_sb_score_i & ~addr_local, int_sb_score_i & addr_local};
  assign clear    = {sb_clear_remote_i, sb_clear_local_i};
  assign clear_id = {sb_clear_remote_id_i, sb_clear_local_id_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sb_r <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (clear[k]) sb_r[clear_id[k]][k] <= 1'b0;
        if (score[k]) sb_r[rd][k] <= 1'b1;  // later assignment wins over clear
      end
    end
  end

  assign dep_hit = ({2{id_reads_rf1_i}} & sb_r[rs1])
                 | ({2{id_reads_rf2_i}} & sb_r[rs2]);

  assign depend_inc        = ~reset_i & stall_depend_i & ~stall_i;
  assign depend_local_inc  = depend_inc & dep_hit[0];
  assign depend_remote_inc = depend_inc & dep_hit[1];

  assign ev.stall_depend        = depend_inc;
  assign ev.stall_depend_local  = depend_local_inc;
  assign ev.stall_depend_remote = depend_remote_inc;

  // a cause is only ever a split of a counted dependency stall
  a_cause_in_depend: assert property (@(posedge clk_i) disable iff (reset_i)
    (depend_local_inc || depend_remote_inc) |-> depend_inc)
    else $error("depend cause strobe without dependency stall");

endmodule

`default_nettype wire

//--- verilog/stat_counter_bank.sv
`default_nettype none

`include "profiler_settings.svh"

module stat_counter_bank (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  profiler_event_if.count                    ev,
  input  wire logic                          stall_md_i,
  input  wire logic                          stall_remote_req_i,

  input  wire logic [`PROF_STAT_SEL_W-1:0]   stat_sel_i,
  output logic [`PROF_CTR_W-1:0]             stat_value_o
);

  logic [`PROF_CTR_W-1:0]    stat_r [`PROF_NUM_STATS];
  logic [`PROF_NUM_STATS-1:0] inc;

  always_comb begin
    inc                              = '0;
    inc[`STAT_CYCLE]                 = 1'b1;  // free running out of reset
    inc[`STAT_INSTR]                 = ev.instr;
    inc[`STAT_BRANCH]                = ev.branch;
    inc[`STAT_BRANCH_MISS]           = ev.branch_miss;
    inc[`STAT_JALR]                  = ev.jalr;
    inc[`STAT_JALR_MISS]             = ev.jalr_miss;
    inc[`STAT_MULDIV]                = ev.muldiv;
    inc[`STAT_LOCAL_LD]              = ev.local_ld;
    inc[`STAT_LOCAL_ST]              = ev.local_st;
    inc[`STAT_REMOTE_LD]             = ev.remote_ld;
    inc[`STAT_REMOTE_ST]             = ev.remote_st;
    inc[`STAT_ICACHE_MISS]           = ev.icache_miss;
    inc[`STAT_STALL_DEPEND]          = ev.stall_depend;
    inc[`STAT_STALL_DEPEND_LOCAL]    = ev.stall_depend_local;
    inc[`STAT_STALL_DEPEND_REMOTE]   = ev.stall_depend_remote;
    // raw stall levels, no priority between causes
    inc[`STAT_STALL_MD]              = stall_md_i;
    inc[`STAT_STALL_REMOTE_REQ]      = stall_remote_req_i;
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `PROF_NUM_STATS; i++) begin
      if (reset_i) begin
        stat_r[i] <= '0;
      end else if (inc[i]) begin
        stat_r[i] <= stat_r[i] + 1'b1;
      end
    end
  end

  // unused select codes read as zero
  assign stat_value_o = (stat_sel_i < `PROF_STAT_SEL_W'(`PROF_NUM_STATS))
    ? stat_r[stat_sel_i] : '0;

  a_sel_range: assert property (@(posedge clk_i) disable iff (reset_i)
    stat_sel_i < `PROF_STAT_SEL_W'(`PROF_NUM_STATS))
    else $error("stat select %0d out of range", stat_sel_i);

endmodule

`default_nettype wire

//--- verilog/core_profiler.sv
`default_nettype none

`include "profiler_settings.svh"

module core_profiler
  import profiler_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  input  wire logic                          stall_i,
  input  wire logic                          stall_depend_i,
  input  wire logic                          stall_md_i,
  input  wire logic                          stall_remote_req_i,

  input  wire logic [`PROF_DATA_W-1:0]       exe_instr_i,
  input  wire logic                          exe_icache_miss_i,
  input  wire logic                          exe_is_branch_i,
  input  wire logic                          exe_is_jalr_i,
  input  wire logic                          exe_writes_rf_i,
  input  wire logic                          exe_reads_rf2_i,
  input  wire logic                          branch_mispredict_i,
  input  wire logic                          jalr_mispredict_i,

  input  wire logic                          lsu_dmem_v_i,
  input  wire logic                          lsu_dmem_w_i,

  input  wire logic                          remote_req_v_i,
  input  wire logic                          remote_req_yumi_i,
  input  wire logic                          remote_req_write_i,
  input  wire remote_payload_u               remote_req_payload_i,

  input  wire logic [`PROF_DATA_W-1:0]       id_instr_i,
  input  wire logic                          id_reads_rf1_i,
  input  wire logic                          id_reads_rf2_i,

  input  wire logic                          int_sb_score_i,
  input  wire logic [`PROF_DATA_W-1:0]       load_base_i,
  input  wire logic [`PROF_DATA_W-1:0]       load_offset_i,
  input  wire logic                          sb_clear_local_i,
  input  wire logic [`PROF_REG_ADDR_W-1:0]   sb_clear_local_id_i,
  input  wire logic                          sb_clear_remote_i,
  input  wire logic [`PROF_REG_ADDR_W-1:0]   sb_clear_remote_id_i,

  input  wire logic [`PROF_STAT_SEL_W-1:0]   stat_sel_i,
  output logic [`PROF_CTR_W-1:0]             stat_value_o
);

  profiler_event_if ev ();

  retire_event_decode i_retire_event_decode (
    .reset_i              (reset_i),
    .stall_i              (stall_i),
    .exe_instr_i          (exe_instr_i),
    .exe_icache_miss_i    (exe_icache_miss_i),
    .exe_is_branch_i      (exe_is_branch_i),
    .exe_is_jalr_i        (exe_is_jalr_i),
    .exe_writes_rf_i      (exe_writes_rf_i),
    .exe_reads_rf2_i      (exe_reads_rf2_i),
    .branch_mispredict_i  (branch_mispredict_i),
    .jalr_mispredict_i    (jalr_mispredict_i),
    .lsu_dmem_v_i         (lsu_dmem_v_i),
    .lsu_dmem_w_i         (lsu_dmem_w_i),
    .remote_req_v_i       (remote_req_v_i),
    .remote_req_yumi_i    (remote_req_yumi_i),
    .remote_req_write_i   (remote_req_write_i),
    .remote_req_payload_i (remote_req_payload_i),
    .ev                   (ev.decode)
  );

  load_origin_scoreboard i_load_origin_scoreboard (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .stall_i              (stall_i),
    .stall_depend_i       (stall_depend_i),
    .id_instr_i           (id_instr_i),
    .id_reads_rf1_i       (id_reads_rf1_i),
    .id_reads_rf2_i       (id_reads_rf2_i),
    .int_sb_score_i       (int_sb_score_i),
    .load_base_i          (load_base_i),
    .load_offset_i        (load_offset_i),
    .sb_clear_local_i     (sb_clear_local_i),
    .sb_clear_local_id_i  (sb_clear_local_id_i),
    .sb_clear_remote_i    (sb_clear_remote_i),
    .sb_clear_remote_id_i (sb_clear_remote_id_i),
    .ev                   (ev.depend)
  );

  stat_counter_bank i_stat_counter_bank (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .ev                 (ev.count),
    .stall_md_i         (stall_md_i),
    .stall_remote_req_i (stall_remote_req_i),
    .stat_sel_i         (stat_sel_i),
    .stat_value_o       (stat_value_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_core_profiler.sv
`default_nettype none

`include "profiler_settings.svh"

module tb_core_profiler
  import profiler_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam string VEC_FILE = "testbench/profiler_vectors.txt";

  logic                          clk_i = 1'b0;
  logic                          reset_i;
  logic                          stall_i, stall_depend_i, stall_md_i, stall_remote_req_i;
  logic [`PROF_DATA_W-1:0]       exe_instr_i;
  logic                          exe_icache_miss_i, exe_is_branch_i, exe_is_jalr_i;
  logic                          exe_writes_rf_i, exe_reads_rf2_i;
  logic                          branch_mispredict_i, jalr_mispredict_i;
  logic                          lsu_dmem_v_i, lsu_dmem_w_i;
  logic                          remote_req_v_i, remote_req_yumi_i, remote_req_write_i;
  remote_payload_u               remote_req_payload_i;
  logic [`PROF_DATA_W-1:0]       id_instr_i;
  logic                          id_reads_rf1_i, id_reads_rf2_i;
  logic                          int_sb_score_i;
  logic [`PROF_DATA_W-1:0]       load_base_i, load_offset_i;
  logic                          sb_clear_local_i, sb_clear_remote_i;
  logic [`PROF_REG_ADDR_W-1:0]   sb_clear_local_id_i, sb_clear_remote_id_i;
  logic [`PROF_STAT_SEL_W-1:0]   stat_sel_i;
  logic [`PROF_CTR_W-1:0]        stat_value_o;

  logic [`PROF_CTR_W-1:0]        edge_count;  // edges since reset release
  int                            cycle_count = 0;
  int                            cycle_limit = 0;
  int                            check_total, error_total;
  int                            test_checks, test_errors;
  string                         cur_test;

  core_profiler i_core_profiler (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (reset_i) begin
      edge_count <= '0;
    end else begin
      edge_count <= edge_count + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("error: timeout, the run went beyond %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic drive_idle();
    stall_i              = 1'b0;
    stall_depend_i       = 1'b0;
    stall_md_i           = 1'b0;
    stall_remote_req_i   = 1'b0;
    exe_instr_i          = '0;
    exe_icache_miss_i    = 1'b0;
    exe_is_branch_i      = 1'b0;
    exe_is_jalr_i        = 1'b0;
    exe_writes_rf_i      = 1'b0;
    exe_reads_rf2_i      = 1'b0;
    branch_mispredict_i  = 1'b0;
    jalr_mispredict_i    = 1'b0;
    lsu_dmem_v_i         = 1'b0;
    lsu_dmem_w_i         = 1'b0;
    remote_req_v_i       = 1'b0;
    remote_req_yumi_i    = 1'b0;
    remote_req_write_i   = 1'b0;
    remote_req_payload_i = '0;
    id_instr_i           = '0;
    id_reads_rf1_i       = 1'b0;
    id_reads_rf2_i       = 1'b0;
    int_sb_score_i       = 1'b0;
    load_base_i          = '0;
    load_offset_i        = '0;
    sb_clear_local_i     = 1'b0;
    sb_clear_remote_i    = 1'b0;
    sb_clear_local_id_i  = '0;
    sb_clear_remote_id_i = '0;
  endtask

  task automatic note_failure(input string msg);
    $display("error: %s", msg);
    error_total++;
    test_errors++;
  endtask

  task automatic finish_test();
    if (cur_test != "") begin
      if (test_errors == 0) begin
        $display("test %s: ok, %0d checks", cur_test, test_checks);
      end else begin
        $display("test %s: %0d of %0d checks wrong", cur_test, test_errors, test_checks);
      end
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic enter_test(input string name);
    if (name != cur_test) begin
      finish_test();
      cur_test = name;
    end
  endtask

  task automatic check_count(input logic [`PROF_CTR_W-1:0] got,
                             input logic [`PROF_CTR_W-1:0] exp, input int idx);
    check_total++;
    test_checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: counter %0d read %0d, expected %0d", $time, idx, got, exp);
      error_total++;
      test_errors++;
    end
  endtask

  task automatic check_cycle(input logic [`PROF_CTR_W-1:0] got);
    check_total++;
    test_checks++;
    if (got !== edge_count) begin
      $display("mismatch at %0t: cycle counter read %0d, %0d edges since reset",
               $time, got, edge_count);
      error_total++;
      test_errors++;
    end
  endtask

  // select on one falling edge and sample on the next
  task automatic read_counter(input int idx, output logic [`PROF_CTR_W-1:0] value);
    @(negedge clk_i);
    drive_idle();
    stat_sel_i = idx[`PROF_STAT_SEL_W-1:0];
    @(negedge clk_i);
    value = stat_value_o;
  endtask

  task automatic apply_stimulus(input string line);
    logic [3:0]                  stl;
    logic [6:0]                  exe;
    logic [4:0]                  mem;
    logic [1:0]                  idf;
    logic [2:0]                  sbf;
    logic [`PROF_DATA_W-1:0]     instr_w, pay_w, id_w, base_w, off_w;
    logic [`PROF_REG_ADDR_W-1:0] cl_id, cr_id;
    int                          n;
    n = $sscanf(line, "S %b %b %b %b %b %h %h %h %h %h %d %d", stl, exe, mem, idf, sbf,
                instr_w, pay_w, id_w, base_w, off_w, cl_id, cr_id);
    if (n != 12) begin
      note_failure($sformatf("malformed stimulus line: %s", line));
    end else begin
      @(negedge clk_i);
      {stall_i, stall_depend_i, stall_md_i, stall_remote_req_i} = stl;
      {exe_icache_miss_i, exe_is_branch_i, exe_is_jalr_i, exe_writes_rf_i,
       exe_reads_rf2_i, branch_mispredict_i, jalr_mispredict_i} = exe;
      {lsu_dmem_v_i, lsu_dmem_w_i, remote_req_v_i, remote_req_yumi_i,
       remote_req_write_i} = mem;
      {id_reads_rf1_i, id_reads_rf2_i} = idf;
      {int_sb_score_i, sb_clear_local_i, sb_clear_remote_i} = sbf;
      exe_instr_i          = instr_w;
      remote_req_payload_i = pay_w;
      id_instr_i           = id_w;
      load_base_i          = base_w;
      load_offset_i        = off_w;
      sb_clear_local_id_i  = cl_id;
      sb_clear_remote_id_i = cr_id;
    end
  endtask

  task automatic run_line(input string line);
    string                  name;
    int                     idx;
    logic [`PROF_CTR_W-1:0] exp_val;
    logic [`PROF_CTR_W-1:0] value;
    byte                    tag;
    tag = line.getc(0);
    case (tag)
      "S": apply_stimulus(line);
      "C": begin
        if ($sscanf(line, "C %s %d %d", name, idx, exp_val) != 3) begin
          note_failure($sformatf("malformed checkpoint line: %s", line));
        end else begin
          enter_test(name);
          read_counter(idx, value);
          check_count(value, exp_val, idx);
        end
      end
      "Z": begin
        if ($sscanf(line, "Z %s", name) != 1) begin
          note_failure($sformatf("malformed checkpoint line: %s", line));
        end else begin
          enter_test(name);
          for (int i = 0; i < `PROF_NUM_STATS; i++) begin
            if (i != `STAT_CYCLE) begin
              read_counter(i, value);
              check_count(value, '0, i);  // everything but cycle clears on reset
            end
          end
        end
      end
      "Y": begin
        if ($sscanf(line, "Y %s", name) != 1) begin
          note_failure($sformatf("malformed checkpoint line: %s", line));
        end else begin
          enter_test(name);
          read_counter(`STAT_CYCLE, value);
          check_cycle(value);
        end
      end
      "#", "\n", "\r", 8'd0: ;
      default: note_failure($sformatf("unknown vector line: %s", line));
    endcase
  endtask

  initial begin
    int    fd;
    int    line_count;
    string line;
    drive_idle();
    stat_sel_i  = '0;
    reset_i     = 1'b1;
    check_total = 0;
    error_total = 0;
    test_checks = 0;
    test_errors = 0;
    cur_test    = "";
    line_count  = 0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("error: cannot open the vectors file %s", VEC_FILE);
      $display("Checks failed");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        line_count++;
      end
      $fclose(fd);
      cycle_limit = line_count * 2 + 64;
      fd = $fopen(VEC_FILE, "r");

      repeat (16) @(negedge clk_i);
      reset_i = 1'b0;

      while ($fgets(line, fd) > 0) begin
        run_line(line);
      end
      $fclose(fd);
      finish_test();

      $display("%0d checks run, %0d errors", check_total, error_total);
      if (error_total == 0 && check_total > 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/profiler_vectors.txt
# S stall/dep/md/rreq  exe ic/br/jr/wrf/rf2/bm/jm  mem dv/dw/rv/ry/rw  id rf1/rf2
#   sb score/clr_l/clr_r, hex exe_instr payload id_instr base offset, dec clr ids l r
# C test index expected | Z test: all but cycle zero | Y test: cycle vs edges
Z reset
Y reset
# retire: addi, beq miss, beq, jalr miss, mul, then stalled, zero word, icache miss
S 0000 0001000 00000 00 000 00100093 00000000 00000000 00000000 00000000 0 0
S 0000 0100010 00000 00 000 00208463 00000000 00000000 00000000 00000000 0 0
S 0000 0100000 00000 00 000 00208463 00000000 00000000 00000000 00000000 0 0
S 0000 0011001 00000 00 000 000080e7 00000000 00000000 00000000 00000000 0 0
S 0000 0001000 00000 00 000 022081b3 00000000 00000000 00000000 00000000 0 0
S 1000 0001000 00000 00 000 022081b3 00000000 00000000 00000000 00000000 0 0
S 0000 0100000 00000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 1001000 00000 00 000 022081b3 00000000 00000000 00000000 00000000 0 0
C retire 1 5
C retire 2 2
C retire 3 1
C retire 4 1
C retire 5 1
C retire 6 1
# memory: local ld, local st, stalled ld, remote st, held remote ld, held fetch
S 0000 0001000 10000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 0000100 11000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 1000 0001000 10000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 0000000 00111 00 000 00000000 12345678 00000000 00000000 00000000 0 0
S 0000 0001000 00100 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 0001000 00100 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 0001000 00110 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0000 0000000 00100 00 000 00000000 80000000 00000000 00000000 00000000 0 0
S 0000 0000000 00110 00 000 00000000 80000000 00000000 00000000 00000000 0 0
C memory 7 1
C memory 8 1
C memory 9 1
C memory 10 1
C memory 11 1
# depend: local load to x5, remote load to x6, stalls on each, clear, stall again
S 0000 0000000 00000 00 100 00000000 00000000 00000283 00001000 00000010 0 0
S 0000 0000000 00000 00 100 00000000 00000000 00000303 20000000 00000004 0 0
S 0100 0000000 00000 10 000 00000000 00000000 000283b3 00000000 00000000 0 0
S 0100 0000000 00000 01 000 00000000 00000000 006003b3 00000000 00000000 0 0
S 0000 0000000 00000 00 011 00000000 00000000 00000000 00000000 00000000 5 6
S 0100 0000000 00000 10 000 00000000 00000000 000283b3 00000000 00000000 0 0
S 0100 0000000 00000 01 000 00000000 00000000 006003b3 00000000 00000000 0 0
S 1100 0000000 00000 10 000 00000000 00000000 000283b3 00000000 00000000 0 0
C depend 12 4
C depend 13 1
C depend 14 1
# raw stall levels
S 0010 0000000 00000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0010 0000000 00000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0011 0000000 00000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
S 0001 0000000 00000 00 000 00000000 00000000 00000000 00000000 00000000 0 0
C raw_stall 15 3
C raw_stall 16 2
Y raw_stall

//--- project.f
+incdir+common
common/profiler_pkg.sv
common/profiler_event_if.sv
verilog/retire_event_decode.sv
verilog/load_origin_scoreboard.sv
verilog/stat_counter_bank.sv
verilog/core_profiler.sv
testbench/tb_core_profiler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the profiler testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_core_profiler \
  -o tb_core_profiler
./obj_dir/tb_core_profiler | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
